/* src/fetch_pkg.sv */
package fetch_pkg;

	// ------------------------------------------------------------------------
	// instruction side widths
	// ------------------------------------------------------------------------

	// byte address as seen by the fetch unit and by decode
	typedef logic [31:0] addr_t;

	// one word as returned by instruction memory
	// fetch always reads whole aligned words, even for compressed code
	typedef logic [31:0] word_t;

	// one instruction parcel, the unit in which the CIR is filled and consumed
	typedef logic [15:0] half_t;

	// architectural register number, x0 to x31
	typedef logic [4:0] regnum_t;

	// number of halfwords, 0 to 2
	// cir_vld tells decode how much of the CIR holds real data and
	// cir_use tells the aligner how much of it decode has consumed
	typedef logic [1:0] hw_count_t;

	// ------------------------------------------------------------------------
	// beat passed from the request stage through the queue to the aligner
	// ------------------------------------------------------------------------

	// the error bit rides along with its data word, so a bus error only
	// surfaces once the affected halfwords reach the CIR and can be flushed
	// by a jump like any other speculative fetch
	typedef struct packed {
		word_t data;
		logic  err;
	} fetch_beat_t;

endpackage

/* src/axi_lite_pkg.sv */
package axi_lite_pkg;

	// address and data widths of the memory port
	typedef logic [31:0] axi_addr_t;
	typedef logic [31:0] axi_data_t;

	// protection field of the address channel
	typedef logic [2:0] axi_prot_t;

	// unprivileged, secure, instruction access
	localparam axi_prot_t AXI_PROT_INSTR = 3'b100;

	// read response codes, anything but OKAY counts as a failed fetch
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_e;

	// read address channel payload, valid and ready travel separately
	typedef struct packed {
		axi_addr_t addr;
		axi_prot_t prot;
	} axi_ar_t;

	// read data channel payload
	typedef struct packed {
		axi_data_t data;
		axi_resp_e resp;
	} axi_r_t;

endpackage

/* src/fetch_request.sv */
module fetch_request #(
	parameter int               QUEUE_DEPTH  = 2,
	parameter fetch_pkg::addr_t RESET_VECTOR = 32'h0000_0000
) (
	input  logic                                 clk,
	input  logic                                 rst_n,
	output axi_lite_pkg::axi_ar_t                ar,
	output logic                                 ar_valid,
	input  logic                                 ar_ready,
	input  axi_lite_pkg::axi_r_t                 r,
	input  logic                                 r_valid,
	output logic                                 r_ready,
	input  fetch_pkg::addr_t                     jump_target,
	input  logic                                 jump_valid,
	output logic                                 jump_ready,
	output logic                                 jump_now,
	input  logic [$clog2(QUEUE_DEPTH + 1) - 1:0] free_slots,
	output fetch_pkg::fetch_beat_t               beat,
	output logic                                 beat_valid
);
	import fetch_pkg::*;
	import axi_lite_pkg::*;

	localparam int SLOT_W = $clog2(QUEUE_DEPTH + 1);

	logic       reset_holdoff;
	logic       addr_hold;
	logic [1:0] pending;
	logic [1:0] flush_cnt;
	addr_t      fetch_addr;
	logic       ar_hs;
	logic       r_hs;
	logic       fetch_stall;
	logic       req_want;
	addr_t      req_addr;

	// --------------------------------------------------------------------------
	// bus bookkeeping
	// --------------------------------------------------------------------------

	assign ar_hs = ar_valid && ar_ready;
	assign r_hs  = r_valid && r_ready;

	// every read in flight was issued only when the queue had a slot for it,
	// so data can be taken whenever anything is outstanding
	assign r_ready = |pending;

	// a jump may not change the address of a request the memory has already
	// seen, and it is also held off while two reads are in flight so that the
	// redirect itself never becomes a third outstanding read
	assign jump_ready = !addr_hold && !pending[1];
	assign jump_now   = jump_valid && jump_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reset_holdoff <= 1'b1;
			addr_hold     <= 1'b0;
			pending       <= 2'd0;
			flush_cnt     <= 2'd0;
		end else begin
			reset_holdoff <= 1'b0;
			addr_hold     <= ar_valid && !ar_ready;
			pending       <= pending + 2'(ar_hs) - 2'(r_hs);
			// reads issued before the jump must not reach the queue
			// a response landing in the jump cycle is already dropped below
			if (jump_now) begin
				flush_cnt <= pending - 2'(r_hs);
			end else if (r_hs && |flush_cnt) begin
				flush_cnt <= flush_cnt - 2'd1;
			end
		end
	end

	// --------------------------------------------------------------------------
	// address generation
	// --------------------------------------------------------------------------

	// fetch address runs ahead of decode in whole words
	// when the jump request is accepted straight away the next word is due next
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_addr <= RESET_VECTOR;
		end else if (jump_now) begin
			fetch_addr <= {jump_target[31:2] + 30'(ar_hs), 2'b00};
		end else if (ar_hs) begin
			fetch_addr <= fetch_addr + 32'd4;
		end
	end

	// a new sequential read needs a free queue slot for it and for every
	// read already in flight, and never more than two reads outstanding
	assign fetch_stall = pending[1] || (free_slots <= SLOT_W'(pending));

	// a held request keeps its address, a jump goes out in the cycle it is
	// taken, otherwise fetch runs ahead while credit allows
	always_comb begin
		req_want = 1'b0;
		req_addr = fetch_addr;
		if (addr_hold) begin
			req_want = 1'b1;
		end else if (jump_now) begin
			req_want = 1'b1;
			req_addr = {jump_target[31:2], 2'b00};
		end else if (!fetch_stall) begin
			req_want = 1'b1;
		end
	end

	// nothing goes out in the first cycle after reset
	assign ar_valid = req_want && !reset_holdoff;
	assign ar.addr  = req_addr;
	assign ar.prot  = AXI_PROT_INSTR;

	// --------------------------------------------------------------------------
	// response to beat
	// --------------------------------------------------------------------------

	assign beat.data  = r.data;
	assign beat.err   = (r.resp != OKAY);
	assign beat_valid = r_hs && (flush_cnt == 2'd0) && !jump_now;

endmodule

/* src/prefetch_queue.sv */
module prefetch_queue #(
	parameter int QUEUE_DEPTH = 2
) (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  fetch_pkg::fetch_beat_t               beat,
	input  logic                                 beat_valid,
	input  logic                                 flush,
	input  logic                                 pop,
	output fetch_pkg::fetch_beat_t               head,
	output logic                                 head_valid,
	output logic [$clog2(QUEUE_DEPTH + 1) - 1:0] free_slots
);
	import fetch_pkg::*;

	fetch_beat_t            entry [QUEUE_DEPTH];
	fetch_beat_t            above [QUEUE_DEPTH];
	logic [QUEUE_DEPTH-1:0] entry_valid;
	logic [QUEUE_DEPTH-1:0] above_valid;
	logic [QUEUE_DEPTH-1:0] valid_popped;
	logic                   push;

	// entry 0 is the head, valid bits always form a run from bit 0 upwards
	// an empty queue passes the incoming beat straight to the aligner
	assign head       = entry_valid[0] ? entry[0] : beat;
	assign head_valid = entry_valid[0] || beat_valid;

	// a bypassed beat that the aligner takes right away is not stored
	assign push = beat_valid && !(pop && !entry_valid[0]);

	// view of the queue one slot up, the incoming beat sits above the last entry
	assign above_valid = {1'b0, entry_valid[QUEUE_DEPTH-1:1]};

	always_comb begin
		for (int i = 0; i < QUEUE_DEPTH - 1; i++) begin
			above[i] = entry[i + 1];
		end
		above[QUEUE_DEPTH - 1] = beat;
	end

	assign valid_popped = pop ? above_valid : entry_valid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			entry_valid <= '0;
		end else if (flush) begin
			entry_valid <= '0;
		end else if (push) begin
			entry_valid <= {valid_popped[QUEUE_DEPTH-2:0], 1'b1};
		end else begin
			entry_valid <= valid_popped;
		end
	end

	// on a pop everything moves down by one and the first free slot picks up
	// the new beat, without a pop only free slots are written
	// free slots above the first one get a copy of the beat that is never read
	always_ff @(posedge clk) begin
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			if (pop || (push && !entry_valid[i])) begin
				entry[i] <= above_valid[i] ? above[i] : beat;
			end
		end
	end

	// fill level comes from registers only, which keeps the memory response
	// out of the request path
	always_comb begin
		free_slots = '0;
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			if (!entry_valid[i]) begin
				free_slots = free_slots + 1'b1;
			end
		end
	end

endmodule

/* src/instr_aligner.sv */
module instr_aligner (
	input  logic                   clk,
	input  logic                   rst_n,
	input  fetch_pkg::fetch_beat_t head,
	input  logic                   head_valid,
	output logic                   pop,
	input  logic                   jump_now,
	input  fetch_pkg::addr_t       jump_target,
	output fetch_pkg::word_t       cir,
	output fetch_pkg::hw_count_t   cir_vld,
	output logic [1:0]             cir_err,
	input  fetch_pkg::hw_count_t   cir_use,
	output fetch_pkg::regnum_t     next_rs1,
	output fetch_pkg::regnum_t     next_rs2
);
	import fetch_pkg::*;

	half_t       hwbuf;
	logic [1:0]  buf_level;
	logic [2:0]  buf_err;
	logic        unaligned_pend;
	half_t [2:0] shifted;
	half_t [2:0] merged;
	logic [2:0]  err_shifted;
	logic [2:0]  err_merged;
	logic [1:0]  level_kept;
	logic [1:0]  level_next;
	logic        overlay_blocked;
	logic        must_refill;
	word_t       next_instr;
	logic [1:0]  quadrant;
	logic [2:0]  funct3;

	// --------------------------------------------------------------------------
	// halfword buffer
	// --------------------------------------------------------------------------

	// {hwbuf, cir} holds up to three halfwords and buf_level counts them
	// first move what decode leaves behind down to position 0
	// positions that will be refilled or are past the level take whatever is cheapest
	always_comb begin
		case (cir_use)
			2'd2: begin
				shifted     = {hwbuf, hwbuf, hwbuf};
				err_shifted = buf_err >> 2;
			end
			2'd1: begin
				shifted     = {hwbuf, hwbuf, cir[31:16]};
				err_shifted = buf_err >> 1;
			end
			default: begin
				shifted     = {hwbuf, cir[31:16], cir[15:0]};
				err_shifted = buf_err;
			end
		endcase
	end

	// decode never uses more than cir_vld, and cir_vld never exceeds the level
	assign level_kept = buf_level - cir_use;

	// a whole word fits only when at most one halfword is left over
	// the first word after an unaligned jump brings just its upper half
	assign overlay_blocked = level_kept[1] && !unaligned_pend;
	assign must_refill     = !level_kept[1];
	assign pop             = must_refill && head_valid;

	// lay fetched data over the leftovers, right after the last valid halfword
	always_comb begin
		if (overlay_blocked) begin
			merged     = shifted;
			err_merged = err_shifted;
		end else if (unaligned_pend) begin
			merged     = {shifted[2], shifted[1], head.data[31:16]};
			err_merged = {err_shifted[2:1], head.err};
		end else if (level_kept[0]) begin
			merged     = {head.data[31:16], head.data[15:0], shifted[0]};
			err_merged = {{2{head.err}}, err_shifted[0]};
		end else begin
			merged     = {shifted[2], head.data[31:16], head.data[15:0]};
			err_merged = {err_shifted[2], {2{head.err}}};
		end
	end

	// a jump empties the buffer, nothing from the old stream reaches the CIR
	always_comb begin
		if (jump_now) begin
			level_next = 2'd0;
		end else if (head_valid && unaligned_pend) begin
			level_next = 2'd1;
		end else begin
			level_next = level_kept + {pop, 1'b0};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			buf_level      <= 2'd0;
			cir_vld        <= 2'd0;
			buf_err        <= 3'd0;
			unaligned_pend <= 1'b0;
		end else begin
			buf_level <= level_next;
			// the CIR shows at most two of the three buffered halfwords
			cir_vld   <= level_next[1] ? 2'd2 : level_next;
			buf_err   <= err_merged;
			// stays set until the first word from the target is taken
			if (jump_now) begin
				unaligned_pend <= jump_target[1];
			end else if (pop) begin
				unaligned_pend <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		{hwbuf, cir} <= merged;
	end

	assign cir_err = buf_err[1:0];

	// --------------------------------------------------------------------------
	// register number predecode
	// --------------------------------------------------------------------------

	// looks at the value the CIR takes on the next cycle, so the register
	// file can be read while that instruction is decoded
	assign next_instr = {merged[1], merged[0]};
	assign quadrant   = next_instr[1:0];
	assign funct3     = next_instr[15:13];

	always_comb begin
		if (quadrant == 2'b11) begin
			next_rs1 = next_instr[19:15];
			next_rs2 = next_instr[24:20];
		end else begin
			// stack relative forms are c.addi4spn, c.lwsp and c.swsp
			if (quadrant == 2'b00 && funct3 == 3'b000) begin
				next_rs1 = 5'd2;
			end else if (quadrant == 2'b10 && funct3[1:0] == 2'b10) begin
				next_rs1 = 5'd2;
			end else if (quadrant == 2'b10) begin
				next_rs1 = next_instr[11:7];
			end else begin
				next_rs1 = {2'b01, next_instr[9:7]};
			end
			// quadrant 2 has full register fields, the others only reach x8 to x15
			if (quadrant == 2'b10) begin
				next_rs2 = next_instr[6:2];
			end else begin
				next_rs2 = {2'b01, next_instr[4:2]};
			end
		end
	end

endmodule

/* src/fetch_frontend.sv */
module fetch_frontend #(
	parameter int               QUEUE_DEPTH  = 2,
	parameter fetch_pkg::addr_t RESET_VECTOR = 32'h0000_0000
) (
	input  logic                   clk,
	input  logic                   rst_n,

	// instruction memory, read half of AXI4-Lite
	output axi_lite_pkg::axi_ar_t  ar,
	output logic                   ar_valid,
	input  logic                   ar_ready,
	input  axi_lite_pkg::axi_r_t   r,
	input  logic                   r_valid,
	output logic                   r_ready,

	// decode side
	output fetch_pkg::word_t       cir,
	output fetch_pkg::hw_count_t   cir_vld,
	output logic [1:0]             cir_err,
	input  fetch_pkg::hw_count_t   cir_use,
	output fetch_pkg::regnum_t     next_rs1,
	output fetch_pkg::regnum_t     next_rs2,
	input  fetch_pkg::addr_t       jump_target,
	input  logic                   jump_valid,
	output logic                   jump_ready
);
	import fetch_pkg::*;

	fetch_beat_t                          beat;
	logic                                 beat_valid;
	fetch_beat_t                          head;
	logic                                 head_valid;
	logic                                 pop;
	logic                                 jump_now;
	logic [$clog2(QUEUE_DEPTH + 1) - 1:0] free_slots;

	// request stage owns the bus and decides when a jump is taken
	fetch_request #(
		.QUEUE_DEPTH  (QUEUE_DEPTH),
		.RESET_VECTOR (RESET_VECTOR)
	) u_request (
		.clk         (clk),
		.rst_n       (rst_n),
		.ar          (ar),
		.ar_valid    (ar_valid),
		.ar_ready    (ar_ready),
		.r           (r),
		.r_valid     (r_valid),
		.r_ready     (r_ready),
		.jump_target (jump_target),
		.jump_valid  (jump_valid),
		.jump_ready  (jump_ready),
		.jump_now    (jump_now),
		.free_slots  (free_slots),
		.beat        (beat),
		.beat_valid  (beat_valid)
	);

	// a taken jump empties the queue together with the aligner
	prefetch_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_queue (
		.clk        (clk),
		.rst_n      (rst_n),
		.beat       (beat),
		.beat_valid (beat_valid),
		.flush      (jump_now),
		.pop        (pop),
		.head       (head),
		.head_valid (head_valid),
		.free_slots (free_slots)
	);

	instr_aligner u_aligner (
		.clk         (clk),
		.rst_n       (rst_n),
		.head        (head),
		.head_valid  (head_valid),
		.pop         (pop),
		.jump_now    (jump_now),
		.jump_target (jump_target),
		.cir         (cir),
		.cir_vld     (cir_vld),
		.cir_err     (cir_err),
		.cir_use     (cir_use),
		.next_rs1    (next_rs1),
		.next_rs2    (next_rs2)
	);

endmodule

/* bench/tb_clock_gen.sv */
module tb_clock_gen #(
	parameter int PERIOD       = 20,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	// free running clock, reset released on a rising edge after the hold time
	initial begin
		clk   = 1'b0;
		rst_n = 1'b0;
		fork
			forever #(PERIOD / 2) clk = ~clk;
			begin
				repeat (RESET_CYCLES) @(posedge clk);
				rst_n <= 1'b1;
			end
		join
	end

endmodule

/* bench/axi_imem_model.sv */
module axi_imem_model #(
	parameter logic [31:0] SEED = 32'h90efdff9
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  axi_lite_pkg::axi_ar_t ar,
	input  logic                  ar_valid,
	output logic                  ar_ready,
	output axi_lite_pkg::axi_r_t  r,
	output logic                  r_valid,
	input  logic                  r_ready,
	input  logic                  mixed,
	input  fetch_pkg::addr_t      err_addr
);
	timeunit 1ns;
	timeprecision 100ps;

	import fetch_pkg::*;
	import axi_lite_pkg::*;

	integer seed;
	int     cycle;
	addr_t  addr_q [$];
	int     due_q  [$];

	// content rule: word address rotated left by 7, xor a constant, then the
	// low bits of the halfwords forced to pick the instruction length
	function automatic word_t pattern(input addr_t byte_addr, input logic mixed_code);
		logic [31:0] a;
		word_t       w;
		a = {2'b00, byte_addr[31:2]};
		w = {a[24:0], a[31:25]} ^ 32'h5a3c_96e1;
		if (mixed_code) begin
			// the word address picks both lengths, so 32-bit instructions
			// start at either halfword and every quadrant turns up
			w[1:0]   = a[1:0];
			w[17:16] = ~a[1:0];
		end else begin
			w[1:0]   = 2'b11;
			w[17:16] = 2'b11;
		end
		return w;
	endfunction

	initial begin
		seed = SEED;
	end

	// ------------------------------------------------------------------------
	// address acceptance and in-order responses with random latency
	// ------------------------------------------------------------------------

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ar_ready <= 1'b0;
			r_valid  <= 1'b0;
			r        <= '0;
			cycle    = 0;
			addr_q.delete();
			due_q.delete();
		end else begin
			cycle = cycle + 1;
			// the response shown this cycle is gone once it is taken
			if (r_valid && r_ready) begin
				void'(addr_q.pop_front());
				void'(due_q.pop_front());
			end
			if (ar_valid && ar_ready) begin
				addr_q.push_back(ar.addr);
				due_q.push_back(cycle + 1 + ($unsigned($random(seed)) % 4));
			end
			// ready about three cycles out of four
			ar_ready <= ($unsigned($random(seed)) % 4) != 0;
			if (addr_q.size() > 0 && due_q[0] <= cycle) begin
				r_valid <= 1'b1;
				r.data  <= pattern(addr_q[0], mixed);
				r.resp  <= (addr_q[0][31:2] == err_addr[31:2]) ? SLVERR : OKAY;
			end else begin
				r_valid <= 1'b0;
			end
		end
	end

endmodule

/* bench/fetch_tb.sv */
module fetch_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import fetch_pkg::*;
	import axi_lite_pkg::*;

	localparam int    QUEUE_DEPTH  = 2;
	localparam addr_t RESET_VECTOR = 32'h0000_1000;
	// halfwords consumed over all tests, 40 cycles allowed for each
	localparam int    TOTAL_HW       = 32 + 40 + 32 + 24 + 40;
	localparam int    TIMEOUT_CYCLES = TOTAL_HW * 40;

	logic      clk;
	logic      rst_n;
	axi_ar_t   ar;
	logic      ar_valid;
	logic      ar_ready;
	axi_r_t    r;
	logic      r_valid;
	logic      r_ready;
	word_t     cir;
	hw_count_t cir_vld;
	logic [1:0] cir_err;
	hw_count_t cir_use;
	regnum_t   next_rs1;
	regnum_t   next_rs2;
	addr_t     jump_target;
	logic      jump_valid;
	logic      jump_ready;
	logic      mixed;
	addr_t     err_addr;

	integer seed;
	int     cycle_count;
	int     rs_checks;
	addr_t  exp_pc;
	logic   rs_pending;
	regnum_t rs1_seen;
	regnum_t rs2_seen;
	logic   ar_waiting;
	addr_t  ar_waiting_addr;

	tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(16)) u_clock (.clk(clk), .rst_n(rst_n));

	axi_imem_model #(.SEED(32'h90efdff9)) u_mem (
		.clk(clk), .rst_n(rst_n), .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
		.r(r), .r_valid(r_valid), .r_ready(r_ready), .mixed(mixed), .err_addr(err_addr)
	);

	fetch_frontend #(.QUEUE_DEPTH(QUEUE_DEPTH), .RESET_VECTOR(RESET_VECTOR)) uut (
		.clk(clk), .rst_n(rst_n), .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
		.r(r), .r_valid(r_valid), .r_ready(r_ready), .cir(cir), .cir_vld(cir_vld),
		.cir_err(cir_err), .cir_use(cir_use), .next_rs1(next_rs1), .next_rs2(next_rs2),
		.jump_target(jump_target), .jump_valid(jump_valid), .jump_ready(jump_ready)
	);

	// ------------------------------------------------------------------------
	// reference model of the halfword stream and of the register predecode
	// ------------------------------------------------------------------------

	function automatic half_t expected_half(input addr_t pc, input logic mixed_code);
		logic [31:0] a;
		word_t       w;
		a = pc >> 2;
		w = ((a << 7) | (a >> 25)) ^ 32'h5a3c_96e1;
		if (mixed_code) begin
			w[1:0]   = a[1:0];
			w[17:16] = ~a[1:0];
		end else begin
			w[17:16] = 2'b11;
			w[1:0]   = 2'b11;
		end
		return pc[1] ? w[31:16] : w[15:0];
	endfunction

	// rs1 in the upper five bits, rs2 in the lower five
	function automatic logic [9:0] expected_regs(input word_t ins);
		logic [2:0] f3;
		f3 = ins[15:13];
		case (ins[1:0])
			2'b11: return {ins[19:15], ins[24:20]};
			2'b00: return {(f3 == 3'b000) ? 5'd2 : {2'b01, ins[9:7]}, 2'b01, ins[4:2]};
			2'b01: return {2'b01, ins[9:7], 2'b01, ins[4:2]};
			default: return {(f3 == 3'b010 || f3 == 3'b110) ? 5'd2 : ins[11:7], ins[6:2]};
		endcase
	endfunction

	task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1, "check failed");
		end
	endtask

	// ------------------------------------------------------------------------
	// monitors
	// ------------------------------------------------------------------------

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SIMULATION FAILED");
			$fatal(1, "timeout");
		end
	end

	// predecode seen in one cycle must match the CIR of the following one
	always @(negedge clk) begin
		if (rs_pending && (cir_vld == 2'd2 || (cir_vld == 2'd1 && cir[1:0] != 2'b11))) begin
			check_equal(32'(rs1_seen), 32'(expected_regs(cir) >> 5), "next_rs1");
			check_equal(32'(rs2_seen), 32'(expected_regs(cir) & 10'h1f), "next_rs2");
			rs_checks = rs_checks + 1;
		end
		rs_pending = rst_n;
		rs1_seen   = next_rs1;
		rs2_seen   = next_rs2;
	end

	// a read address stays put until the memory takes it
	// every request is an unprivileged secure instruction access
	always @(negedge clk) begin
		if (ar_waiting) begin
			check_equal(32'(ar_valid), 32'd1, "ar_valid dropped before ar_ready");
			check_equal(ar.addr, ar_waiting_addr, "ar.addr changed before ar_ready");
		end
		if (ar_valid) begin
			check_equal(32'(ar.prot), 32'h4, "ar.prot");
		end
		ar_waiting      = rst_n && ar_valid && !ar_ready;
		ar_waiting_addr = ar.addr;
	end

	// ------------------------------------------------------------------------
	// decode side tasks
	// ------------------------------------------------------------------------

	// every consume cycle follows a cycle with cir_use at 0, so the halfwords
	// sampled at the falling edge are still in place when they are used
	task automatic consume(input int count, input int max_stall);
		int         taken;
		int         take;
		word_t      s_cir;
		hw_count_t  s_vld;
		logic [1:0] s_err;
		half_t      hw;
		taken = 0;
		while (taken < count) begin
			@(negedge clk);
			s_cir = cir;
			s_vld = cir_vld;
			s_err = cir_err;
			if (s_vld == 2'd0) begin
				take = 0;
			end else if (s_cir[1:0] == 2'b11) begin
				take = (s_vld == 2'd2) ? 2 : 0;
			end else begin
				take = 1;
			end
			for (int i = 0; i < take; i++) begin
				hw = (i == 0) ? s_cir[15:0] : s_cir[31:16];
				check_equal(32'(hw), 32'(expected_half(exp_pc, mixed)), "cir halfword");
				check_equal(32'(s_err[i]), 32'(exp_pc[31:2] == err_addr[31:2]), "cir_err bit");
				exp_pc = exp_pc + 32'd2;
			end
			@(posedge clk);
			if (take > 0) begin
				cir_use <= hw_count_t'(take);
				@(posedge clk);
				cir_use <= 2'd0;
				taken = taken + take;
				if (max_stall > 0) begin
					repeat ($unsigned($random(seed)) % (max_stall + 1)) @(posedge clk);
				end
			end
		end
	endtask

	// mode and error address change only with a jump, whose flush drops
	// every word fetched under the old settings
	task automatic jump_to(input addr_t target, input logic mixed_code, input addr_t bad);
		@(posedge clk);
		jump_valid  <= 1'b1;
		jump_target <= target;
		mixed       <= mixed_code;
		err_addr    <= bad;
		@(negedge clk);
		while (!jump_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		jump_valid <= 1'b0;
		exp_pc = target;
	endtask

	task automatic sequential_words;
		exp_pc = RESET_VECTOR;
		consume(32, 0);
	endtask

	task automatic compressed_mix;
		jump_to(32'h0000_2000, 1'b1, 32'hffff_fff0);
		consume(40, 0);
	endtask

	task automatic jumps_in_flight;
		jump_to(32'h0000_4002, 1'b1, 32'hffff_fff0);
		consume(8, 0);
		jump_to(32'h0000_4100, 1'b0, 32'hffff_fff0);
		consume(8, 0);
		jump_to(32'h0000_4206, 1'b1, 32'hffff_fff0);
		consume(8, 0);
		jump_to(32'h0000_4300, 1'b1, 32'hffff_fff0);
		consume(8, 0);
	endtask

	// the word before the error word ends in a 32-bit instruction that
	// spans into it, so one CIR shows a clean and a failed halfword
	task automatic bus_error_flags;
		jump_to(32'h0000_3000, 1'b1, 32'h0000_3014);
		consume(24, 0);
	endtask

	task automatic decode_backpressure;
		jump_to(32'h0000_5000, 1'b1, 32'h0000_5010);
		consume(40, 7);
	endtask

	initial begin
		seed            = 32'h90efdff9;
		cycle_count     = 0;
		rs_checks       = 0;
		rs_pending      = 1'b0;
		ar_waiting      = 1'b0;
		ar_waiting_addr = '0;
		cir_use         = 2'd0;
		jump_valid      = 1'b0;
		jump_target     = '0;
		mixed           = 1'b0;
		err_addr        = 32'hffff_fff0;
		@(posedge rst_n);
		sequential_words();
		compressed_mix();
		jumps_in_flight();
		bus_error_flags();
		decode_backpressure();
		if (rs_checks == 0) begin
			$display("predecode was never checked, no complete instruction seen");
			$display("SIMULATION FAILED");
			$fatal(1, "no predecode checks");
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

/* all.f */
src/fetch_pkg.sv
src/axi_lite_pkg.sv
src/fetch_request.sv
src/prefetch_queue.sv
src/instr_aligner.sv
src/fetch_frontend.sv
bench/tb_clock_gen.sv
bench/axi_imem_model.sv
bench/fetch_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= fetch_tb
RTL_TOP   ?= fetch_frontend
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing -Wno-fatal
JOBS      ?= 4

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) \
		src/fetch_pkg.sv src/axi_lite_pkg.sv src/fetch_request.sv \
		src/prefetch_queue.sv src/instr_aligner.sv src/fetch_frontend.sv
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
